// File: logic/huff_pkg.sv
package huff_pkg;

    localparam int TOKEN_W    = 16;               // rll token from zigzag stage
    localparam int VALUE_W    = 12;               // signed coefficient
    localparam int CAT_W      = 4;                // magnitude category / length
    localparam int CODE_W     = 16;               // output word to stuffer
    localparam int FIFO_DEPTH = 16;               // input token buffer
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // token field positions
    localparam int TOK_COEF_BIT   = 15;           // 1 - coefficient, 0 - control
    localparam int TOK_DC_BIT     = 14;           // coefficient is DC
    localparam int TOK_CHROMA_BIT = 13;           // chroma table, valid on DC
    localparam int TOK_LAST_BIT   = 12;           // last / EOB marker
    localparam int RUN_W          = 4;            // zero run before next AC
    localparam int ZRL_LSB        = 4;            // ZRL count starts here
    localparam int ZRL_W          = 2;            // up to 3 ZRL codes

    typedef enum logic [1:0] {
        TOK_DC,                                   // DC coefficient
        TOK_AC,                                   // AC coefficient
        TOK_RUN,                                  // zero run, maybe with ZRL codes
        TOK_EOB                                   // end of block
    } token_kind_e;

    typedef enum logic [2:0] {
        S_IDLE,                                   // wait for a token
        S_LOOKUP,                                 // table read for DC/AC/EOB
        S_CODE,                                   // huffman code to output
        S_VALUE,                                  // magnitude bits to output
        S_ZRL,                                    // table read for 16-zero code
        S_FLUSH                                   // last word gone, flush stuffer
    } seq_state_e;

    // decode bits 15, 14, 12 into a token kind
    function automatic token_kind_e token_kind(input logic [TOKEN_W-1:0] tok);
        token_kind_e kind;
        if (tok[TOK_COEF_BIT]) kind = tok[TOK_DC_BIT] ? TOK_DC : TOK_AC;
        else kind = tok[TOK_LAST_BIT] ? TOK_EOB : TOK_RUN;
        return kind;
    endfunction

endpackage

// File: logic/huff_table_pkg.sv
package huff_table_pkg;

    localparam int SYM_W      = 8;                // huffman symbol, {run, category}
    localparam int TAB_ADDR_W = SYM_W + 1;        // msb selects chroma half
    localparam int TAB_DEPTH  = 1 << TAB_ADDR_W;  // luma + chroma entries
    localparam int TAB_DATA_W = 20;               // {len[3:0], code[15:0]}
    localparam int TAB_LEN_LSB = 16;              // length field position

    // special symbols
    localparam logic [SYM_W-1:0] SYM_EOB = 8'h00; // end of block
    localparam logic [SYM_W-1:0] SYM_ZRL = 8'hF0; // sixteen zeros

    // DC codes sit at {category, 4'hf}, cells unused by AC symbols
    localparam logic [3:0] DC_COLUMN = 4'hf;

endpackage

// File: logic/huff_fifo.sv
`timescale 1ns/1ps

module huff_fifo
    import huff_pkg::*;
(
    input  logic               xclk,      // pixel clock
    input  logic               rst_n_i,   // sync reset, active low
    input  logic               push_i,    // token strobe from rll stage
    input  logic [TOKEN_W-1:0] din_i,     // token in
    input  logic               pop_i,     // sequencer takes head token
    output logic               valid_o,   // head entry holds data
    output logic [TOKEN_W-1:0] dout_o     // head token
);

    logic [TOKEN_W-1:0] mem [FIFO_DEPTH]; // token storage
    logic [FIFO_AW:0]   wr_ptr;           // extra msb tells full from empty
    logic [FIFO_AW:0]   rd_ptr;
    logic               full;

    assign valid_o = (wr_ptr != rd_ptr);
    assign full    = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                     (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign dout_o  = mem[rd_ptr[FIFO_AW-1:0]]; // head shown without read latency

    always_ff @(posedge xclk) begin
        if (push_i) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= din_i;
        end
    end

    always_ff @(posedge xclk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i && valid_o) begin                // ignore pop on empty
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // no input back-pressure, so the source must respect the depth
    a_no_overflow: assert property (
        @(posedge xclk) disable iff (!rst_n_i)
        push_i |-> !full
    ) else $error("huff_fifo: token pushed into full buffer");

endmodule

// File: logic/varlen_encode.sv
`timescale 1ns/1ps

module varlen_encode
    import huff_pkg::*;
(
    input  logic signed [VALUE_W-1:0] value_i, // signed coefficient
    output logic        [CAT_W-1:0]   cat_o,   // magnitude bit length
    output logic        [CODE_W-1:0]  bits_o   // value bits, right aligned
);

    logic [VALUE_W-1:0] mag;                   // absolute value
    logic [VALUE_W-1:0] adj;                   // one's complement for negatives
    logic [CODE_W-1:0]  mask;                  // low cat_o bits set

    assign mag = value_i[VALUE_W-1] ? -value_i : value_i; // -2048 gives 12'h800
    assign adj = value_i[VALUE_W-1] ? value_i - VALUE_W'(1) : value_i;

    // priority encoder, highest set bit wins
    always_comb begin
        cat_o = '0;
        for (int i = 0; i < VALUE_W; i++) begin
            if (mag[i]) begin
                cat_o = CAT_W'(i + 1);
            end
        end
    end

    assign mask   = (CODE_W'(1) << cat_o) - CODE_W'(1); // zero for category 0
    assign bits_o = {{(CODE_W - VALUE_W){1'b0}}, adj} & mask;

endmodule

// File: logic/huff_table.sv
`timescale 1ns/1ps

module huff_table
    import huff_pkg::*, huff_table_pkg::*;
(
    input  logic                  xclk,      // pixel clock, both ports
    input  logic                  we_i,      // table write strobe
    input  logic [TAB_ADDR_W-1:0] waddr_i,   // {chroma, symbol}
    input  logic [TAB_DATA_W-1:0] wdata_i,   // {len, code}
    input  logic                  re_i,      // read enable, holds data when low
    input  logic [TAB_ADDR_W-1:0] raddr_i,
    output logic [CODE_W-1:0]     code_o,    // huffman code, msb aligned by len
    output logic [CAT_W-1:0]      len_o      // 0 means 16 bits
);

    logic [TAB_DATA_W-1:0] mem [TAB_DEPTH];  // luma half, then chroma half
    logic [TAB_DATA_W-1:0] rd_q;             // registered read entry

    always_ff @(posedge xclk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (re_i) begin
            rd_q <= mem[raddr_i];            // one cycle latency
        end
    end

    assign code_o = rd_q[TAB_LEN_LSB-1:0];
    assign len_o  = rd_q[TAB_DATA_W-1:TAB_LEN_LSB];

endmodule

// File: logic/huff_sequencer.sv
`timescale 1ns/1ps

module huff_sequencer
    import huff_pkg::*, huff_table_pkg::*;
(
    input  logic                      xclk,         // pixel clock
    input  logic                      rst_n_i,      // sync reset, active low
    input  logic                      fifo_valid_i, // head token present
    input  logic [TOKEN_W-1:0]        fifo_token_i, // head token
    output logic                      fifo_pop_o,   // token consumed this cycle
    output logic                      tab_re_o,     // table read strobe
    output logic [TAB_ADDR_W-1:0]     tab_addr_o,   // {chroma, symbol}
    input  logic [CODE_W-1:0]         tab_code_i,   // valid cycle after tab_re_o
    input  logic [CAT_W-1:0]          tab_len_i,
    output logic signed [VALUE_W-1:0] vle_value_o,  // coefficient to categorize
    input  logic [CAT_W-1:0]          vle_cat_i,    // combinational from vle
    input  logic [CODE_W-1:0]         vle_bits_i,
    input  logic                      rdy_i,        // stuffer ready
    output logic [CODE_W-1:0]         do_o,         // output word
    output logic [CAT_W-1:0]          dl_o,         // word length, 0 means 16
    output logic                      dv_o,         // word valid
    output logic                      flush_o,      // frame done, flush stuffer
    output logic                      last_block_o  // inside last block of frame
);

    seq_state_e                state;
    token_kind_e               kind_q;       // token being encoded
    token_kind_e               pop_kind;     // kind of fifo head
    logic                      chroma_q;     // table half, from DC
    logic signed [VALUE_W-1:0] val_q;        // coefficient of token in flight
    logic [RUN_W-1:0]          run_q;        // zeros before next AC
    logic [ZRL_W-1:0]          zrl_cnt;      // ZRL codes still due
    logic                      last_word_q;  // token in flight closes the frame
    logic [SYM_W-1:0]          sym;          // low table address bits
    logic                      has_value;    // value word follows the code
    logic                      token_done;   // final word of token loads now
    logic                      word_ld;      // output register takes new word
    logic [CODE_W-1:0]         word_code;
    logic [CAT_W-1:0]          word_len;

    assign pop_kind    = token_kind(fifo_token_i);
    assign fifo_pop_o  = (state == S_IDLE) && fifo_valid_i && rdy_i; // frozen on stall
    assign vle_value_o = val_q;
    assign has_value   = ((kind_q == TOK_DC) || (kind_q == TOK_AC)) && (vle_cat_i != '0);
    assign token_done  = ((state == S_CODE) && (kind_q != TOK_RUN) && !has_value) ||
                         (state == S_VALUE);

    // table symbol for the pending lookup
    always_comb begin
        if (state == S_ZRL) begin
            sym = SYM_ZRL;
        end else begin
            case (kind_q)
                TOK_DC:  sym = {vle_cat_i, DC_COLUMN}; // spare AC cells
                TOK_AC:  sym = {run_q, vle_cat_i};     // run/size symbol
                default: sym = SYM_EOB;
            endcase
        end
    end

    assign tab_addr_o = {chroma_q, sym};
    assign tab_re_o   = ((state == S_LOOKUP) || (state == S_ZRL)) && rdy_i; // keep data on stall

    // next output word
    always_comb begin
        word_ld   = 1'b0;
        word_code = tab_code_i;
        word_len  = tab_len_i;
        case (state)
            S_CODE: begin
                word_ld = 1'b1;                    // code from table
            end
            S_VALUE: begin
                word_ld   = 1'b1;
                word_code = vle_bits_i;            // magnitude bits
                word_len  = vle_cat_i;
            end
            default: begin
                word_ld = 1'b0;
            end
        endcase
    end

    always_ff @(posedge xclk) begin
        if (!rst_n_i) begin
            dv_o <= 1'b0;
        end else if (rdy_i) begin
            dv_o <= word_ld;                       // word held while stuffer busy
        end
    end

    always_ff @(posedge xclk) begin
        if (rdy_i && word_ld) begin
            do_o <= word_code;
            dl_o <= word_len;
        end
    end

    always_ff @(posedge xclk) begin
        if (fifo_pop_o) begin
            val_q <= fifo_token_i[VALUE_W-1:0];    // only used for DC/AC
        end
    end

    always_ff @(posedge xclk) begin
        if (!rst_n_i) begin
            state        <= S_IDLE;
            kind_q       <= TOK_EOB;
            chroma_q     <= 1'b0;
            run_q        <= '0;
            zrl_cnt      <= '0;
            last_word_q  <= 1'b0;
            last_block_o <= 1'b0;
            flush_o      <= 1'b0;
        end else if (rdy_i) begin
            case (state)
                S_IDLE: begin
                    if (fifo_valid_i) begin
                        kind_q      <= pop_kind;
                        last_word_q <= last_block_o && (pop_kind != TOK_DC) &&
                                       fifo_token_i[TOK_LAST_BIT];
                        case (pop_kind)
                            TOK_DC: begin
                                chroma_q <= fifo_token_i[TOK_CHROMA_BIT]; // whole block
                                if (fifo_token_i[TOK_LAST_BIT]) begin
                                    last_block_o <= 1'b1;
                                end
                                state <= S_LOOKUP;
                            end
                            TOK_RUN: begin
                                run_q   <= fifo_token_i[RUN_W-1:0];
                                zrl_cnt <= fifo_token_i[ZRL_LSB +: ZRL_W];
                                if (fifo_token_i[ZRL_LSB +: ZRL_W] != '0) begin
                                    state <= S_ZRL;
                                end
                            end
                            default: begin
                                state <= S_LOOKUP;     // AC or EOB
                            end
                        endcase
                    end
                end
                S_LOOKUP: begin
                    state <= S_CODE;
                end
                S_ZRL: begin
                    state <= S_CODE;
                end
                S_CODE: begin
                    if (kind_q == TOK_RUN) begin
                        zrl_cnt <= zrl_cnt - 1'b1;
                        state   <= (zrl_cnt == 1) ? S_IDLE : S_ZRL;
                    end else if (has_value) begin
                        state <= S_VALUE;
                    end
                    if (kind_q == TOK_AC) begin
                        run_q <= '0;                  // run used up by this AC
                    end
                end
                S_FLUSH: begin
                    if (!flush_o) begin
                        flush_o <= 1'b1;              // last word accepted this cycle
                    end else begin
                        flush_o      <= 1'b0;
                        last_block_o <= 1'b0;
                        last_word_q  <= 1'b0;
                        state        <= S_IDLE;
                    end
                end
                default: begin
                    state <= state;                   // S_VALUE, exits below
                end
            endcase
            if (token_done) begin
                state <= last_word_q ? S_FLUSH : S_IDLE;
            end
        end
    end

    a_word_stable: assert property (
        @(posedge xclk) disable iff (!rst_n_i)
        (dv_o && !rdy_i) |=> (dv_o && $stable(do_o) && $stable(dl_o))
    ) else $error("huff_sequencer: output word changed under back-pressure");

    a_flush_no_dv: assert property (
        @(posedge xclk) disable iff (!rst_n_i)
        !(flush_o && dv_o)
    ) else $error("huff_sequencer: flush raised with a word pending");

endmodule

// File: logic/huff_encoder.sv
`timescale 1ns/1ps

module huff_encoder
    import huff_pkg::*, huff_table_pkg::*;
(
    input  logic                  xclk,          // pixel clock
    input  logic                  rst_n_i,       // sync reset, active low
    input  logic [TOKEN_W-1:0]    di_i,          // rll token
    input  logic                  ds_i,          // token strobe
    input  logic                  table_we_i,    // table write, while idle
    input  logic [TAB_ADDR_W-1:0] table_addr_i,
    input  logic [TAB_DATA_W-1:0] table_data_i,
    input  logic                  rdy_i,         // stuffer ready
    output logic [CODE_W-1:0]     do_o,          // code or value bits
    output logic [CAT_W-1:0]      dl_o,          // length, 0 means 16
    output logic                  dv_o,
    output logic                  flush_o,       // flush rest of bits
    output logic                  last_block_o
);

    logic                      fifo_valid;
    logic [TOKEN_W-1:0]        fifo_token;
    logic                      fifo_pop;
    logic                      tab_re;
    logic [TAB_ADDR_W-1:0]     tab_addr;
    logic [CODE_W-1:0]         tab_code;
    logic [CAT_W-1:0]          tab_len;
    logic signed [VALUE_W-1:0] vle_value;
    logic [CAT_W-1:0]          vle_cat;
    logic [CODE_W-1:0]         vle_bits;

    huff_fifo u_huff_fifo (
        .xclk    (xclk),
        .rst_n_i (rst_n_i),
        .push_i  (ds_i),
        .din_i   (di_i),
        .pop_i   (fifo_pop),
        .valid_o (fifo_valid),
        .dout_o  (fifo_token)
    );

    huff_sequencer u_huff_sequencer (
        .xclk         (xclk),
        .rst_n_i      (rst_n_i),
        .fifo_valid_i (fifo_valid),
        .fifo_token_i (fifo_token),
        .fifo_pop_o   (fifo_pop),
        .tab_re_o     (tab_re),
        .tab_addr_o   (tab_addr),
        .tab_code_i   (tab_code),
        .tab_len_i    (tab_len),
        .vle_value_o  (vle_value),
        .vle_cat_i    (vle_cat),
        .vle_bits_i   (vle_bits),
        .rdy_i        (rdy_i),
        .do_o         (do_o),
        .dl_o         (dl_o),
        .dv_o         (dv_o),
        .flush_o      (flush_o),
        .last_block_o (last_block_o)
    );

    huff_table u_huff_table (
        .xclk    (xclk),
        .we_i    (table_we_i),
        .waddr_i (table_addr_i),
        .wdata_i (table_data_i),
        .re_i    (tab_re),
        .raddr_i (tab_addr),
        .code_o  (tab_code),
        .len_o   (tab_len)
    );

    varlen_encode u_varlen_encode (
        .value_i (vle_value),
        .cat_o   (vle_cat),
        .bits_o  (vle_bits)
    );

endmodule

// File: tb/tb_huff_encoder.sv
`timescale 1ns/1ps

module tb_huff_encoder
    import huff_pkg::*, huff_table_pkg::*;
();

    localparam int CYCLE_LIMIT = 20000;             // tokens x 8 cycles x stall factor, plus margin

    logic                    xclk;
    logic                    rst_n_i;
    logic [TOKEN_W-1:0]      di_i;
    logic                    ds_i;
    logic                    table_we_i;
    logic [TAB_ADDR_W-1:0]   table_addr_i;
    logic [TAB_DATA_W-1:0]   table_data_i;
    logic                    rdy_i;
    logic [CODE_W-1:0]       do_o;
    logic [CAT_W-1:0]        dl_o;
    logic                    dv_o;
    logic                    flush_o;
    logic                    last_block_o;

    logic [CODE_W+CAT_W-1:0] exp_q [$];             // expected {len, code}, oldest first
    string                   cur_test;
    int                      errors;
    int                      checks;
    int                      cycle_cnt = 0;
    logic [31:0]             lfsr_q;
    logic                    rand_rdy;              // stuffer ready taken from lfsr
    logic                    model_chroma;          // table half of current block
    logic [3:0]              model_run;             // zero run waiting for next AC

    huff_encoder u_huff_encoder (
        .xclk         (xclk),
        .rst_n_i      (rst_n_i),
        .di_i         (di_i),
        .ds_i         (ds_i),
        .table_we_i   (table_we_i),
        .table_addr_i (table_addr_i),
        .table_data_i (table_data_i),
        .rdy_i        (rdy_i),
        .do_o         (do_o),
        .dl_o         (dl_o),
        .dv_o         (dv_o),
        .flush_o      (flush_o),
        .last_block_o (last_block_o)
    );

    initial begin
        xclk = 1'b0;
        forever #50 xclk = ~xclk;                   // 100 ns period
    end

    always @(posedge xclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_bit()};              // one step per bit
        end
        return r;
    endfunction

    // bit length of |v|
    function automatic int mag_category(input int v);
        int m;
        int c;
        m = (v < 0) ? -v : v;
        c = 0;
        while (m > 0) begin
            m = m >> 1;
            c = c + 1;
        end
        return c;
    endfunction

    function automatic logic [CODE_W-1:0] value_bits(input int v, input int cat);
        int adj;
        adj = (v < 0) ? v - 1 : v;                  // negatives sent as v - 1
        return CODE_W'(adj & ((1 << cat) - 1));
    endfunction

    function automatic logic [CODE_W-1:0] entry_code(input logic [TAB_ADDR_W-1:0] addr);
        return CODE_W'(addr) ^ 16'h5a5a;
    endfunction

    function automatic logic [CAT_W-1:0] entry_len(input logic [TAB_ADDR_W-1:0] addr);
        return CAT_W'((int'(addr) % 15) + 1);      // never 0, so never 16 bits
    endfunction

    task automatic expect_word(input logic [CODE_W-1:0] code, input logic [CAT_W-1:0] len);
        exp_q.push_back({len, code});
    endtask

    task automatic expect_entry(input logic [TAB_ADDR_W-1:0] addr);
        expect_word(entry_code(addr), entry_len(addr));
    endtask

    // reference model, one token in, expected words appended
    task automatic model_token(input logic [TOKEN_W-1:0] tok);
        int v;
        int cat;
        v   = int'($signed(tok[11:0]));
        cat = mag_category(v);
        if (tok[15]) begin
            if (tok[14]) begin                      // DC, picks table half
                model_chroma = tok[13];
                expect_entry({model_chroma, cat[3:0], DC_COLUMN});
            end else begin
                expect_entry({model_chroma, model_run, cat[3:0]});
                model_run = '0;
            end
            if (cat != 0) begin
                expect_word(value_bits(v, cat), CAT_W'(cat));
            end
        end else if (tok[12]) begin
            expect_entry({model_chroma, SYM_EOB});
        end else begin
            model_run = tok[3:0];
            for (int i = 0; i < int'(tok[5:4]); i++) begin
                expect_entry({model_chroma, SYM_ZRL});
            end
        end
    endtask

    task automatic check_code(input string name, input logic [CODE_W-1:0] exp,
                              input logic [CODE_W-1:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: code expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_len(input string name, input logic [CAT_W-1:0] exp,
                             input logic [CAT_W-1:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: length expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("FAILED %s: flag expected %b, actual %b", name, exp, act);
        end
    endtask

    // word taken by the stuffer at the coming edge
    task automatic sample_output();
        logic [CODE_W+CAT_W-1:0] exp;
        if (dv_o && rdy_i) begin
            check_flag(cur_test, 1'b0, flush_o);    // no flush while a word goes out
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("%s: DUT sent a word no token accounts for, code %h length %0d",
                         cur_test, do_o, dl_o);
            end else begin
                exp = exp_q.pop_front();
                check_code(cur_test, exp[CODE_W-1:0], do_o);
                check_len(cur_test, exp[CODE_W +: CAT_W], dl_o);
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge xclk);                            // outputs settled here
        sample_output();
        @(posedge xclk);
        #1;
        if (rand_rdy) begin
            rdy_i = lfsr_bit();
        end
    endtask

    task automatic push_token(input logic [TOKEN_W-1:0] tok);
        model_token(tok);
        di_i = tok;
        ds_i = 1'b1;
        next_cycle();
        ds_i = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (8) next_cycle();                    // any extra word shows up here
    endtask

    task automatic load_table();
        for (int a = 0; a < TAB_DEPTH; a++) begin
            table_we_i   = 1'b1;
            table_addr_i = TAB_ADDR_W'(a);
            table_data_i = {entry_len(TAB_ADDR_W'(a)), entry_code(TAB_ADDR_W'(a))};
            next_cycle();
        end
        table_we_i = 1'b0;
    endtask

    task automatic test_dc();
        cur_test = "test_dc";
        push_token(16'hC005);                       // luma +5
        push_token(16'hEFFD);                       // chroma -3
        push_token(16'hC000);                       // luma 0, code only
        push_token(16'hE3FF);                       // chroma 1023
        push_token(16'hC800);                       // luma -2048, category 12
        wait_drained();
        check_flag(cur_test, 1'b0, flush_o);
        check_flag(cur_test, 1'b0, last_block_o);
    endtask

    task automatic test_ac_run();
        cur_test = "test_ac_run";
        push_token(16'hC002);
        push_token(16'h0005);                       // run 5, no ZRL
        push_token(16'h8FF9);                       // AC -7 at run 5
        push_token(16'h800C);                       // AC +12, run back to 0
        push_token(16'h1000);
        push_token(16'hE000);                       // chroma block
        push_token(16'h0002);
        push_token(16'h8FFF);                       // AC -1
        push_token(16'h1000);
        wait_drained();
    endtask

    task automatic test_zrl_eob();
        cur_test = "test_zrl_eob";
        push_token(16'hC001);
        push_token(16'h0034);                       // three ZRL, then run 4
        push_token(16'h8003);
        push_token(16'h1000);
        wait_drained();
    endtask

    task automatic test_backpressure();
        logic [15:0]               r;
        logic [15:0]               z;
        logic signed [VALUE_W-1:0] val;
        logic [TOKEN_W-1:0]        tok;
        int                        sh;
        cur_test = "test_backpressure";
        rand_rdy = 1'b1;
        for (int i = 0; i < 40; i++) begin
            r   = lfsr_bits(12);
            sh  = int'(lfsr_bits(3));
            val = $signed(r[VALUE_W-1:0]) >>> sh;   // spread over categories
            if (i == 0) begin
                tok = {2'b11, lfsr_bit(), 1'b0, val};
            end else if (i == 39) begin
                tok = 16'h1000;
            end else if ((i % 8 == 7) || (lfsr_bits(2) != 16'h0)) begin
                tok = {4'b1000, val};               // burst ends on an AC
            end else begin
                z   = lfsr_bits(2);
                r   = lfsr_bits(4);
                tok = {10'b0, z[1:0], r[3:0]};
            end
            push_token(tok);
            if ((i % 8 == 7) || (i == 39)) begin
                wait_drained();                     // keeps fifo well below depth
            end
        end
        rand_rdy = 1'b0;
        rdy_i    = 1'b1;
    endtask

    task automatic test_flush();
        cur_test = "test_flush";
        push_token(16'hD009);                       // last block, luma DC
        push_token(16'h0001);
        push_token(16'h8006);
        push_token(16'h8FFE);
        push_token(16'h1000);                       // EOB closes the frame
        while (!flush_o) begin
            check_flag(cur_test, 1'b1, last_block_o);
            next_cycle();
        end
        check_flag(cur_test, 1'b1, exp_q.size() == 0); // final word already taken
        check_flag(cur_test, 1'b0, dv_o);
        rdy_i = 1'b0;
        repeat (3) begin
            next_cycle();
            check_flag(cur_test, 1'b1, flush_o);    // held through stall
            check_flag(cur_test, 1'b1, last_block_o);
        end
        rdy_i = 1'b1;
        next_cycle();
        check_flag(cur_test, 1'b0, flush_o);
        check_flag(cur_test, 1'b0, last_block_o);
        wait_drained();
    endtask

    initial begin
        rst_n_i      = 1'b0;
        di_i         = '0;
        ds_i         = 1'b0;
        table_we_i   = 1'b0;
        table_addr_i = '0;
        table_data_i = '0;
        rdy_i        = 1'b1;
        errors       = 0;
        checks       = 0;
        lfsr_q       = 32'h2ec4;
        rand_rdy     = 1'b0;
        model_chroma = 1'b0;
        model_run    = '0;
        cur_test     = "reset";
        repeat (10) @(posedge xclk);
        #1;
        rst_n_i = 1'b1;
        check_flag(cur_test, 1'b0, dv_o);
        check_flag(cur_test, 1'b0, flush_o);
        check_flag(cur_test, 1'b0, last_block_o);
        load_table();
        test_dc();
        test_ac_run();
        test_zrl_eob();
        test_backpressure();
        test_flush();
        if (exp_q.size() != 0) begin
            errors = errors + 1;
            $display("%0d expected words were never sent by the DUT", exp_q.size());
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/huff_pkg.sv
logic/huff_table_pkg.sv
logic/huff_fifo.sv
logic/varlen_encode.sv
logic/huff_table.sv
logic/huff_sequencer.sv
logic/huff_encoder.sv
tb/tb_huff_encoder.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_huff_encoder -f compile.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
